// ==== Bender.yml ====
package:
  name: id_stage

sources:
  - files:
      - src/idPkg.sv
      - src/decodeCtrlIf.sv
      - src/idPipeReg.sv
      - src/insDecoder.sv
      - src/regFile.sv
      - src/operandFetch.sv
      - src/branchUnit.sv
      - src/idStage.sv
  - target: test
    files:
      - verif/idStageChk.sv
      - verif/idStageTb.sv

// ==== filelist.f ====
src/idPkg.sv
src/decodeCtrlIf.sv
src/idPipeReg.sv
src/insDecoder.sv
src/regFile.sv
src/operandFetch.sv
src/branchUnit.sv
src/idStage.sv
verif/idStageChk.sv
verif/idStageTb.sv

// ==== src/branchUnit.sv ====
`timescale 1ns/1ps

module branchUnit import idPkg::*; (
    input  logic              idValid,
    input  logic [DATA_W-1:0] idNextPc,
    input  insWord_u          ins,
    input  logic [DATA_W-1:0] rdata1,
    input  logic [DATA_W-1:0] rdata2,
    decodeCtrlIf.branch       ctrl,
    output logic [DATA_W-1:0] pcBranch,
    output logic              pcSrc
);
    logic [15:0]       imm;
    logic [DATA_W-1:0] brTarget;
    logic [DATA_W-1:0] jTarget;
    logic              isEqual;
    logic              isZero;
    logic              isNeg;
    logic              condOk;

    assign imm      = insImm(ins);
    assign brTarget = idNextPc + {{(DATA_W-18){imm[15]}}, imm, 2'b00};
    assign jTarget  = {idNextPc[DATA_W-1:DATA_W-4], ins.jType.target, 2'b00}; // same 256MB region

    assign isEqual = (rdata1 == rdata2);
    assign isZero  = (rdata1 == '0);
    assign isNeg   = rdata1[DATA_W-1];

    always_comb begin
        case (ctrl.brCond)
            COND_EQ:  condOk = isEqual;
            COND_NE:  condOk = !isEqual;
            COND_GEZ: condOk = !isNeg;
            COND_GTZ: condOk = !isNeg && !isZero;
            COND_LEZ: condOk = isNeg || isZero;
            COND_LTZ: condOk = isNeg;
            default:  condOk = 1'b0;
        endcase
    end

    assign pcBranch = ctrl.jumpReg    ? rdata1  :
                      ctrl.jumpDirect ? jTarget : brTarget;

    // redirect only for an item that is really in the stage
    assign pcSrc = idValid && ((ctrl.isBranch && condOk) || ctrl.jumpDirect || ctrl.jumpReg);
endmodule

// ==== src/decodeCtrlIf.sv ====
`timescale 1ns/1ps

interface decodeCtrlIf import idPkg::*; ();
    logic [ALU_CTRL_W-1:0] aluControl;
    logic                  regWrite;
    logic                  memWrite;
    logic                  memToReg;
    logic                  regDst;      // 1 writes rd, 0 writes rt
    logic                  aluSrc1;     // 0 takes the shift amount
    logic                  aluSrc2;     // 0 takes the immediate
    logic                  extUnsigned;
    logic                  wriReg31;
    logic                  wriPcPlus8;
    logic [BR_COND_W-1:0]  brCond;
    logic                  isBranch;    // conditional branches only
    logic                  jumpDirect;
    logic                  jumpReg;
    logic                  insReserved;

    modport decoder (
        output aluControl, regWrite, memWrite, memToReg, regDst, aluSrc1, aluSrc2,
        output extUnsigned, wriReg31, wriPcPlus8,
        output brCond, isBranch, jumpDirect, jumpReg, insReserved
    );

    modport branch (input brCond, isBranch, jumpDirect, jumpReg);

    modport sink (
        input aluControl, regWrite, memWrite, memToReg, regDst, aluSrc1, aluSrc2,
        input extUnsigned, wriReg31, wriPcPlus8, insReserved
    );
endinterface

// ==== src/idPipeReg.sv ====
`timescale 1ns/1ps

module idPipeReg import idPkg::*; (
    input  logic              clk,
    input  logic              resetn,
    input  logic              ifToIdValid,
    input  logic              idStall,
    input  logic              exAllowin,
    input  logic [DATA_W-1:0] nextPc,
    input  logic [DATA_W-1:0] pc,
    input  insWord_u          insIn,
    output logic              idValid,
    output logic              idAllowin,
    output logic              idToExValid,
    output logic [DATA_W-1:0] idNextPc,
    output logic [DATA_W-1:0] idPc,
    output insWord_u          ins
);
    logic readyGo;

    assign readyGo     = ~idStall;
    assign idAllowin   = !idValid || (readyGo && exAllowin);
    assign idToExValid = idValid && readyGo;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            idValid <= 1'b0;
        end else if (idAllowin) begin
            idValid <= ifToIdValid; // bubble when fetch has nothing
        end
    end

    always_ff @(posedge clk) begin
        if (ifToIdValid && idAllowin) begin
            idNextPc <= nextPc;
            idPc     <= pc;
            ins      <= insIn;
        end
    end
endmodule

// ==== src/idPkg.sv ====
package idPkg;

    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int REG_NUM    = 32;

    localparam int ALU_CTRL_W = 5;
    localparam logic [ALU_CTRL_W-1:0] ALU_ADD  = 5'd0;
    localparam logic [ALU_CTRL_W-1:0] ALU_LUI  = 5'd1;
    localparam logic [ALU_CTRL_W-1:0] ALU_SUB  = 5'd2;
    localparam logic [ALU_CTRL_W-1:0] ALU_SLT  = 5'd3;
    localparam logic [ALU_CTRL_W-1:0] ALU_SLTU = 5'd4;
    localparam logic [ALU_CTRL_W-1:0] ALU_AND  = 5'd5;
    localparam logic [ALU_CTRL_W-1:0] ALU_OR   = 5'd6;
    localparam logic [ALU_CTRL_W-1:0] ALU_XOR  = 5'd7;
    localparam logic [ALU_CTRL_W-1:0] ALU_NOR  = 5'd8;
    localparam logic [ALU_CTRL_W-1:0] ALU_SLL  = 5'd9;
    localparam logic [ALU_CTRL_W-1:0] ALU_SRL  = 5'd10;
    localparam logic [ALU_CTRL_W-1:0] ALU_SRA  = 5'd11;

    localparam int BR_COND_W = 3;
    localparam logic [BR_COND_W-1:0] COND_NONE = 3'd0;
    localparam logic [BR_COND_W-1:0] COND_EQ   = 3'd1;
    localparam logic [BR_COND_W-1:0] COND_NE   = 3'd2;
    localparam logic [BR_COND_W-1:0] COND_GEZ  = 3'd3;
    localparam logic [BR_COND_W-1:0] COND_GTZ  = 3'd4;
    localparam logic [BR_COND_W-1:0] COND_LEZ  = 3'd5;
    localparam logic [BR_COND_W-1:0] COND_LTZ  = 3'd6;

    localparam int FWD_W = 2;
    localparam logic [FWD_W-1:0] FWD_NONE = 2'd0;
    localparam logic [FWD_W-1:0] FWD_ME   = 2'd1; // memory stage result
    localparam logic [FWD_W-1:0] FWD_WB   = 2'd2; // writeback result

    localparam logic [5:0] OP_SPECIAL = 6'b000000;
    localparam logic [5:0] OP_REGIMM  = 6'b000001;
    localparam logic [5:0] OP_J       = 6'b000010;
    localparam logic [5:0] OP_JAL     = 6'b000011;
    localparam logic [5:0] OP_BEQ     = 6'b000100;
    localparam logic [5:0] OP_BNE     = 6'b000101;
    localparam logic [5:0] OP_BLEZ    = 6'b000110;
    localparam logic [5:0] OP_BGTZ    = 6'b000111;
    localparam logic [5:0] OP_ADDIU   = 6'b001001;
    localparam logic [5:0] OP_SLTI    = 6'b001010;
    localparam logic [5:0] OP_SLTIU   = 6'b001011;
    localparam logic [5:0] OP_ANDI    = 6'b001100;
    localparam logic [5:0] OP_ORI     = 6'b001101;
    localparam logic [5:0] OP_XORI    = 6'b001110;
    localparam logic [5:0] OP_LUI     = 6'b001111;
    localparam logic [5:0] OP_LW      = 6'b100011;
    localparam logic [5:0] OP_SW      = 6'b101011;

    localparam logic [5:0] FN_SLL  = 6'b000000;
    localparam logic [5:0] FN_SRL  = 6'b000010;
    localparam logic [5:0] FN_SRA  = 6'b000011;
    localparam logic [5:0] FN_JR   = 6'b001000;
    localparam logic [5:0] FN_JALR = 6'b001001;
    localparam logic [5:0] FN_ADDU = 6'b100001;
    localparam logic [5:0] FN_SUBU = 6'b100011;
    localparam logic [5:0] FN_AND  = 6'b100100;
    localparam logic [5:0] FN_OR   = 6'b100101;
    localparam logic [5:0] FN_XOR  = 6'b100110;
    localparam logic [5:0] FN_NOR  = 6'b100111;
    localparam logic [5:0] FN_SLT  = 6'b101010;
    localparam logic [5:0] FN_SLTU = 6'b101011;

    localparam logic [REG_ADDR_W-1:0] RT_BLTZ = 5'b00000; // rt selects the REGIMM branch
    localparam logic [REG_ADDR_W-1:0] RT_BGEZ = 5'b00001;
    localparam logic [REG_ADDR_W-1:0] REG_RA  = 5'd31;

    typedef struct packed {
        logic [5:0]            op;
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        logic [REG_ADDR_W-1:0] rd;
        logic [4:0]            shamt;
        logic [5:0]            funct;
    } rType_s;

    typedef struct packed {
        logic [5:0]  op;
        logic [25:0] target;
    } jType_s;

    typedef union packed {
        rType_s rType;
        jType_s jType;
    } insWord_u;

    // I-type immediate sits over rd, shamt and funct
    function automatic logic [15:0] insImm(input insWord_u w);
        return {w.rType.rd, w.rType.shamt, w.rType.funct};
    endfunction

endpackage

// ==== src/idStage.sv ====
`timescale 1ns/1ps

module idStage import idPkg::*; (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic [DATA_W-1:0]     nextPc,
    input  logic [DATA_W-1:0]     pc,
    input  logic [DATA_W-1:0]     insWord,
    input  logic                  ifToIdValid,
    input  logic                  idStall,
    input  logic                  exAllowin,
    input  logic [DATA_W-1:0]     meFinalData,
    input  logic                  wbRegWrite,
    input  logic                  wbValid,
    input  logic [REG_ADDR_W-1:0] wbWriteReg,
    input  logic [DATA_W-1:0]     wbFinalData,
    input  logic [FWD_W-1:0]      forwardA,
    input  logic [FWD_W-1:0]      forwardB,
    output logic                  idValid,
    output logic                  idAllowin,
    output logic                  idToExValid,
    output logic [DATA_W-1:0]     idNextPc,
    output logic [DATA_W-1:0]     idPc,
    output logic [REG_ADDR_W-1:0] idRs,
    output logic [REG_ADDR_W-1:0] idRt,
    output logic [REG_ADDR_W-1:0] idRd,
    output logic [DATA_W-1:0]     idExtImm,
    output logic [DATA_W-1:0]     idShamt,
    output logic [ALU_CTRL_W-1:0] aluControl,
    output logic                  regWrite,
    output logic                  memWrite,
    output logic                  memToReg,
    output logic                  regDst,
    output logic                  aluSrc1,
    output logic                  aluSrc2,
    output logic                  wriReg31,
    output logic                  wriPcPlus8,
    output logic                  insReserved,
    output logic [DATA_W-1:0]     idRdata1,
    output logic [DATA_W-1:0]     idRdata2,
    output logic [DATA_W-1:0]     pcBranch,
    output logic                  pcSrc
);
    insWord_u ins; // captured word

    decodeCtrlIf ctrlIf ();

    idPipeReg idPipeReg_i (
        .clk         (clk),
        .resetn      (resetn),
        .ifToIdValid (ifToIdValid),
        .idStall     (idStall),
        .exAllowin   (exAllowin),
        .nextPc      (nextPc),
        .pc          (pc),
        .insIn       (insWord),
        .idValid     (idValid),
        .idAllowin   (idAllowin),
        .idToExValid (idToExValid),
        .idNextPc    (idNextPc),
        .idPc        (idPc),
        .ins         (ins)
    );

    insDecoder insDecoder_i (
        .ins  (ins),
        .ctrl (ctrlIf.decoder)
    );

    operandFetch operandFetch_i (
        .clk         (clk),
        .ins         (ins),
        .extUnsigned (ctrlIf.extUnsigned),
        .wbRegWrite  (wbRegWrite),
        .wbValid     (wbValid),
        .wbWriteReg  (wbWriteReg),
        .wbFinalData (wbFinalData),
        .meFinalData (meFinalData),
        .forwardA    (forwardA),
        .forwardB    (forwardB),
        .rdata1      (idRdata1),
        .rdata2      (idRdata2),
        .extImm      (idExtImm),
        .shamtImm    (idShamt)
    );

    branchUnit branchUnit_i (
        .idValid  (idValid),
        .idNextPc (idNextPc),
        .ins      (ins),
        .rdata1   (idRdata1),
        .rdata2   (idRdata2),
        .ctrl     (ctrlIf.branch),
        .pcBranch (pcBranch),
        .pcSrc    (pcSrc)
    );

    assign idRs = ins.rType.rs;
    assign idRt = ins.rType.rt;
    assign idRd = ins.rType.rd;

    assign aluControl  = ctrlIf.aluControl;
    assign regWrite    = ctrlIf.regWrite;
    assign memWrite    = ctrlIf.memWrite;
    assign memToReg    = ctrlIf.memToReg;
    assign regDst      = ctrlIf.regDst;
    assign aluSrc1     = ctrlIf.aluSrc1;
    assign aluSrc2     = ctrlIf.aluSrc2;
    assign wriReg31    = ctrlIf.wriReg31;
    assign wriPcPlus8  = ctrlIf.wriPcPlus8;
    assign insReserved = ctrlIf.insReserved;
endmodule

// ==== src/insDecoder.sv ====
`timescale 1ns/1ps

module insDecoder import idPkg::*; (
    input insWord_u          ins,
    decodeCtrlIf.decoder     ctrl
);
    logic [5:0]            op;
    logic [5:0]            funct;
    logic [REG_ADDR_W-1:0] rt;

    assign op    = ins.rType.op;
    assign funct = ins.rType.funct;
    assign rt    = ins.rType.rt;

    always_comb begin
        ctrl.aluControl  = ALU_ADD; // address and link adds use the adder
        ctrl.regWrite    = 1'b1;
        ctrl.memWrite    = 1'b0;
        ctrl.memToReg    = 1'b0;
        ctrl.regDst      = (op == OP_SPECIAL);
        ctrl.aluSrc2     = (op == OP_SPECIAL);
        ctrl.aluSrc1     = 1'b1;
        ctrl.extUnsigned = 1'b0;
        ctrl.wriReg31    = 1'b0;
        ctrl.wriPcPlus8  = 1'b0;
        ctrl.brCond      = COND_NONE;
        ctrl.isBranch    = 1'b0;
        ctrl.jumpDirect  = 1'b0;
        ctrl.jumpReg     = 1'b0;
        ctrl.insReserved = 1'b0;

        case (op)
            OP_SPECIAL: begin
                ctrl.aluSrc1 = !(funct inside {FN_SLL, FN_SRL, FN_SRA}); // constant shifts
                case (funct)
                    FN_ADDU: ctrl.aluControl = ALU_ADD;
                    FN_SUBU: ctrl.aluControl = ALU_SUB;
                    FN_SLT:  ctrl.aluControl = ALU_SLT;
                    FN_SLTU: ctrl.aluControl = ALU_SLTU;
                    FN_AND:  ctrl.aluControl = ALU_AND;
                    FN_OR:   ctrl.aluControl = ALU_OR;
                    FN_XOR:  ctrl.aluControl = ALU_XOR;
                    FN_NOR:  ctrl.aluControl = ALU_NOR;
                    FN_SLL:  ctrl.aluControl = ALU_SLL;
                    FN_SRL:  ctrl.aluControl = ALU_SRL;
                    FN_SRA:  ctrl.aluControl = ALU_SRA;
                    FN_JR: begin
                        ctrl.jumpReg  = 1'b1;
                        ctrl.regWrite = 1'b0;
                    end
                    FN_JALR: begin
                        ctrl.jumpReg    = 1'b1;
                        ctrl.wriPcPlus8 = 1'b1; // link goes to rd
                    end
                    default: begin
                        ctrl.insReserved = 1'b1;
                        ctrl.regWrite    = 1'b0;
                    end
                endcase
            end
            OP_ADDIU: ctrl.aluControl = ALU_ADD;
            OP_SLTI:  ctrl.aluControl = ALU_SLT;
            OP_SLTIU: ctrl.aluControl = ALU_SLTU;
            OP_ANDI, OP_ORI, OP_XORI: begin
                ctrl.extUnsigned = 1'b1;
                ctrl.aluControl  = (op == OP_ANDI) ? ALU_AND :
                                   (op == OP_ORI)  ? ALU_OR  : ALU_XOR;
            end
            OP_LUI:   ctrl.aluControl = ALU_LUI;
            OP_LW:    ctrl.memToReg = 1'b1;
            OP_SW: begin
                ctrl.memWrite = 1'b1;
                ctrl.regWrite = 1'b0;
            end
            OP_BEQ, OP_BNE: begin
                ctrl.isBranch = 1'b1;
                ctrl.regWrite = 1'b0;
                ctrl.brCond   = (op == OP_BEQ) ? COND_EQ : COND_NE;
            end
            OP_BLEZ, OP_BGTZ: begin
                ctrl.regWrite    = 1'b0;
                ctrl.isBranch    = (rt == '0); // rt must be zero here
                ctrl.insReserved = (rt != '0);
                ctrl.brCond      = (op == OP_BLEZ) ? COND_LEZ : COND_GTZ;
            end
            OP_REGIMM: begin
                ctrl.regWrite    = 1'b0;
                ctrl.isBranch    = (rt == RT_BLTZ) || (rt == RT_BGEZ);
                ctrl.insReserved = !((rt == RT_BLTZ) || (rt == RT_BGEZ));
                ctrl.brCond      = (rt == RT_BGEZ) ? COND_GEZ : COND_LTZ;
            end
            OP_J: begin
                ctrl.jumpDirect = 1'b1;
                ctrl.regWrite   = 1'b0;
            end
            OP_JAL: begin
                ctrl.jumpDirect = 1'b1;
                ctrl.wriReg31   = 1'b1;
                ctrl.wriPcPlus8 = 1'b1;
            end
            default: begin
                ctrl.insReserved = 1'b1;
                ctrl.regWrite    = 1'b0;
            end
        endcase
    end
endmodule

// ==== src/operandFetch.sv ====
`timescale 1ns/1ps

module operandFetch import idPkg::*; (
    input  logic                  clk,
    input  insWord_u              ins,
    input  logic                  extUnsigned,
    input  logic                  wbRegWrite,
    input  logic                  wbValid,
    input  logic [REG_ADDR_W-1:0] wbWriteReg,
    input  logic [DATA_W-1:0]     wbFinalData,
    input  logic [DATA_W-1:0]     meFinalData,
    input  logic [FWD_W-1:0]      forwardA,
    input  logic [FWD_W-1:0]      forwardB,
    output logic [DATA_W-1:0]     rdata1,
    output logic [DATA_W-1:0]     rdata2,
    output logic [DATA_W-1:0]     extImm,
    output logic [DATA_W-1:0]     shamtImm
);
    logic [DATA_W-1:0] fileData1;
    logic [DATA_W-1:0] fileData2;
    logic [15:0]       imm;

    function automatic logic [DATA_W-1:0] fwdSel(input logic [FWD_W-1:0] sel,
            input logic [DATA_W-1:0] meData, input logic [DATA_W-1:0] wbData,
            input logic [DATA_W-1:0] fileData);
        case (sel)
            FWD_ME:  return meData;
            FWD_WB:  return wbData;
            default: return fileData;
        endcase
    endfunction

    regFile regFile_i (
        .clk    (clk),
        .raddr1 (ins.rType.rs),
        .raddr2 (ins.rType.rt),
        .rdata1 (fileData1),
        .rdata2 (fileData2),
        .we     (wbRegWrite && wbValid),
        .waddr  (wbWriteReg),
        .wdata  (wbFinalData)
    );

    assign rdata1 = fwdSel(forwardA, meFinalData, wbFinalData, fileData1);
    assign rdata2 = fwdSel(forwardB, meFinalData, wbFinalData, fileData2);

    assign imm      = insImm(ins);
    assign extImm   = {{(DATA_W-16){imm[15] && !extUnsigned}}, imm}; // zero ext for logic ops
    assign shamtImm = {{(DATA_W-5){1'b0}}, ins.rType.shamt};
endmodule

// ==== src/regFile.sv ====
`timescale 1ns/1ps

module regFile import idPkg::*; (
    input  logic                  clk,
    input  logic [REG_ADDR_W-1:0] raddr1,
    input  logic [REG_ADDR_W-1:0] raddr2,
    output logic [DATA_W-1:0]     rdata1,
    output logic [DATA_W-1:0]     rdata2,
    input  logic                  we,
    input  logic [REG_ADDR_W-1:0] waddr,
    input  logic [DATA_W-1:0]     wdata
);
    logic [DATA_W-1:0] regs [REG_NUM];

    always_ff @(posedge clk) begin
        if (we) begin
            regs[waddr] <= wdata; // no same-cycle bypass
        end
    end

    // $0 is hardwired whatever was written into it
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];
endmodule

// ==== verif/idStageChk.sv ====
`timescale 1ns/1ps

module idStageChk import idPkg::*; (
    input logic              clk,
    input logic              resetn,
    input logic              idValid,
    input logic              idAllowin,
    input logic              idToExValid,
    input logic [DATA_W-1:0] idPc
);
    int failCount = 0;

    resetClearsValid: assert property (@(posedge clk) !resetn |=> !idValid)
        else begin
            failCount++;
            $error("idValid is set in the cycle after reset");
        end

    forwardNeedsValid: assert property (@(posedge clk) disable iff (!resetn)
            idToExValid |-> idValid)
        else begin
            failCount++;
            $error("idToExValid is high while idValid is low");
        end

    // held item keeps its pc
    pcHeldUnderStall: assert property (@(posedge clk) disable iff (!resetn)
            (idValid && !idAllowin) |=> $stable(idPc))
        else begin
            failCount++;
            $error("idPc changed while the stage was holding an item");
        end
endmodule

// ==== verif/idStageTb.sv ====
`timescale 1ns/1ps

module idStageTb import idPkg::*; ();
    logic                  clk;
    logic                  resetn;
    logic [DATA_W-1:0]     nextPc;
    logic [DATA_W-1:0]     pc;
    logic [DATA_W-1:0]     insWord;
    logic                  ifToIdValid;
    logic                  idStall;
    logic                  exAllowin;
    logic [DATA_W-1:0]     meFinalData;
    logic                  wbRegWrite;
    logic                  wbValid;
    logic [REG_ADDR_W-1:0] wbWriteReg;
    logic [DATA_W-1:0]     wbFinalData;
    logic [FWD_W-1:0]      forwardA;
    logic [FWD_W-1:0]      forwardB;
    logic                  idValid;
    logic                  idAllowin;
    logic                  idToExValid;
    logic [DATA_W-1:0]     idNextPc;
    logic [DATA_W-1:0]     idPc;
    logic [REG_ADDR_W-1:0] idRs;
    logic [REG_ADDR_W-1:0] idRt;
    logic [REG_ADDR_W-1:0] idRd;
    logic [DATA_W-1:0]     idExtImm;
    logic [DATA_W-1:0]     idShamt;
    logic [ALU_CTRL_W-1:0] aluControl;
    logic                  regWrite;
    logic                  memWrite;
    logic                  memToReg;
    logic                  regDst;
    logic                  aluSrc1;
    logic                  aluSrc2;
    logic                  wriReg31;
    logic                  wriPcPlus8;
    logic                  insReserved;
    logic [DATA_W-1:0]     idRdata1;
    logic [DATA_W-1:0]     idRdata2;
    logic [DATA_W-1:0]     pcBranch;
    logic                  pcSrc;

    // current trace record
    logic [DATA_W-1:0]     curPc;
    logic [DATA_W-1:0]     curIns;
    logic [ALU_CTRL_W-1:0] expAlu;
    logic [8:0]            expFlags;    // regWrite down to insReserved
    logic [DATA_W-1:0]     expRdata1;
    logic [DATA_W-1:0]     expRdata2;
    logic [DATA_W-1:0]     expExtImm;
    logic [DATA_W-1:0]     expPcBranch;
    logic                  expPcSrc;

    string traceLines[$];
    int    wordErrors = 0;
    int    aluErrors = 0;
    int    bitErrors = 0;
    int    regErrors = 0;
    int    otherErrors = 0;
    int    cycleCount = 0;
    int    cycleLimit = 20;

    idStage dut_i (.*);

    bind idStage idStageChk idStageChk_i (
        .clk         (clk),
        .resetn      (resetn),
        .idValid     (idValid),
        .idAllowin   (idAllowin),
        .idToExValid (idToExValid),
        .idPc        (idPc)
    );

    always #50 clk = ~clk; // 100 ns period

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            $display("run timed out after %0d cycles, the DUT stopped accepting items",
                     cycleCount);
            $display("Some tests failed");
            $finish;
        end
    end

    task automatic checkWord(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
            input string what);
        if (got !== exp) begin
            wordErrors++;
            $display("FAILED at %0t: %s is %h, expected %h (ins %h)", $time, what, got, exp,
                     curIns);
        end
    endtask

    task automatic checkAluCtrl(input logic [ALU_CTRL_W-1:0] got,
            input logic [ALU_CTRL_W-1:0] exp, input string what);
        if (got !== exp) begin
            aluErrors++;
            $display("FAILED at %0t: %s is %0d, expected %0d (ins %h)", $time, what, got, exp,
                     curIns);
        end
    endtask

    task automatic checkBit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            bitErrors++;
            $display("FAILED at %0t: %s is %b, expected %b (ins %h)", $time, what, got, exp,
                     curIns);
        end
    endtask

    task automatic checkRegAddr(input logic [REG_ADDR_W-1:0] got,
            input logic [REG_ADDR_W-1:0] exp, input string what);
        if (got !== exp) begin
            regErrors++;
            $display("FAILED at %0t: %s is %0d, expected %0d (ins %h)", $time, what, got, exp,
                     curIns);
        end
    endtask

    task automatic loadTrace();
        int    fd;
        int    n;
        string line;
        fd = $fopen("verif/idTrace.txt", "r");
        if (fd == 0) begin
            otherErrors++;
            $display("the trace file verif/idTrace.txt could not be opened");
        end else begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                if (n > 1 && line.getc(0) != "#") begin
                    traceLines.push_back(line);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic checkOutputs();
        checkBit(idValid, 1'b1, "idValid");
        checkWord(idPc, curPc, "idPc");
        checkWord(idNextPc, curPc + 32'd4, "idNextPc");
        checkRegAddr(idRs, curIns[25:21], "idRs"); // register fields of the word
        checkRegAddr(idRt, curIns[20:16], "idRt");
        checkRegAddr(idRd, curIns[15:11], "idRd");
        checkAluCtrl(aluControl, expAlu, "aluControl");
        checkBit(regWrite, expFlags[8], "regWrite");
        checkBit(memWrite, expFlags[7], "memWrite");
        checkBit(memToReg, expFlags[6], "memToReg");
        checkBit(regDst, expFlags[5], "regDst");
        checkBit(aluSrc1, expFlags[4], "aluSrc1");
        checkBit(aluSrc2, expFlags[3], "aluSrc2");
        checkBit(wriReg31, expFlags[2], "wriReg31");
        checkBit(wriPcPlus8, expFlags[1], "wriPcPlus8");
        checkBit(insReserved, expFlags[0], "insReserved");
        checkWord(idRdata1, expRdata1, "idRdata1");
        checkWord(idRdata2, expRdata2, "idRdata2");
        checkWord(idExtImm, expExtImm, "idExtImm");
        checkWord(idShamt, {{(DATA_W-5){1'b0}}, curIns[10:6]}, "idShamt"); // shift field
        checkWord(pcBranch, expPcBranch, "pcBranch");
        checkBit(pcSrc, expPcSrc, "pcSrc");
    endtask

    task automatic writeRegister(input string line);
        logic [REG_ADDR_W-1:0] addr;
        logic [DATA_W-1:0]     data;
        if ($sscanf(line, "W %h %h", addr, data) != 2) begin
            otherErrors++;
            $display("malformed register record in the trace: %s", line);
        end else begin
            wbRegWrite  = 1'b1;
            wbValid     = 1'b1;
            wbWriteReg  = addr;
            wbFinalData = data;
            @(negedge clk);
            wbRegWrite = 1'b0;
            wbValid    = 1'b0;
        end
    endtask

    task automatic runInstruction(input string line);
        logic             stall;
        logic             allowin;
        logic [FWD_W-1:0] fwdA;
        logic [FWD_W-1:0] fwdB;
        logic [DATA_W-1:0] meData;
        logic [DATA_W-1:0] wbData;
        if ($sscanf(line, "I %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h", curPc, curIns,
                stall, allowin, fwdA, fwdB, meData, wbData, expAlu, expFlags, expRdata1,
                expRdata2, expExtImm, expPcBranch, expPcSrc) != 15) begin
            otherErrors++;
            $display("malformed instruction record in the trace: %s", line);
        end else begin
            pc          = curPc;
            nextPc      = curPc + 32'd4;
            insWord     = curIns;
            ifToIdValid = 1'b1;
            forwardA    = fwdA;
            forwardB    = fwdB;
            meFinalData = meData;
            wbFinalData = wbData;
            #25;
            while (!idAllowin) begin // wait for the stage to take the item
                @(negedge clk);
                #25;
            end
            @(negedge clk);
            ifToIdValid = 1'b0;
            checkOutputs();
            idStall   = stall;
            exAllowin = allowin;
            #25;
            checkBit(idAllowin, !stall && allowin, "idAllowin");
            checkBit(idToExValid, !stall, "idToExValid");
            if (stall || !allowin) begin
                pc          = ~curPc; // another item waits behind the held one
                nextPc      = ~curPc + 32'd4;
                insWord     = ~curIns;
                ifToIdValid = 1'b1;
                @(negedge clk);
                checkOutputs(); // held under back-pressure
                ifToIdValid = 1'b0;
                idStall     = 1'b0;
                exAllowin   = 1'b1;
            end
            @(negedge clk);
        end
    endtask

    initial begin
        int totalErrors;
        clk         = 1'b0;
        resetn      = 1'b0;
        nextPc      = '0;
        pc          = '0;
        insWord     = '0;
        ifToIdValid = 1'b0;
        idStall     = 1'b0;
        exAllowin   = 1'b1;
        meFinalData = '0;
        wbRegWrite  = 1'b0;
        wbValid     = 1'b0;
        wbWriteReg  = '0;
        wbFinalData = '0;
        forwardA    = FWD_NONE;
        forwardB    = FWD_NONE;
        curIns      = '0;
        loadTrace();
        cycleLimit = traceLines.size() * 4 + 20;
        repeat (3) @(posedge clk);
        @(negedge clk);
        checkBit(idValid, 1'b0, "idValid after reset");
        checkBit(idToExValid, 1'b0, "idToExValid after reset");
        checkBit(pcSrc, 1'b0, "pcSrc after reset");
        checkBit(idAllowin, 1'b1, "idAllowin after reset");
        resetn = 1'b1;
        foreach (traceLines[i]) begin
            if (traceLines[i].getc(0) == "W") begin
                writeRegister(traceLines[i]);
            end else if (traceLines[i].getc(0) == "I") begin
                runInstruction(traceLines[i]);
            end else begin
                otherErrors++;
                $display("unknown record kind in the trace: %s", traceLines[i]);
            end
        end
        totalErrors = wordErrors + aluErrors + bitErrors + regErrors + otherErrors
                    + dut_i.idStageChk_i.failCount;
        $display("error counts: word %0d, alu %0d, bit %0d, reg %0d, other %0d, assertion %0d",
                 wordErrors, aluErrors, bitErrors, regErrors, otherErrors,
                 dut_i.idStageChk_i.failCount);
        if (totalErrors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end
endmodule

// ==== verif/idTrace.txt ====
# W reg data : write data into a register through the writeback port
# I pc ins stall exAllowin fwdA fwdB meData wbData alu flags rdata1 rdata2 extImm pcBranch pcSrc
# flags msb first: regWrite memWrite memToReg regDst aluSrc1 aluSrc2 wriReg31 wriPcPlus8 reserved
W 01 00000005
W 02 0000000a
W 03 ffffff00
W 04 00000005
W 00 12345678
W 1f 00400100
I 1000fffc 00222821 0 0 0 0 11111111 22222222 00 138 00000005 0000000a 00002821 1001a084 0
I 2000fffc 00603023 0 1 0 0 11111111 22222222 02 138 ffffff00 00000000 00003023 2001c08c 0
I 3000fffc 0061382a 0 1 0 1 11111111 22222222 03 138 ffffff00 11111111 0000382a 3001e0a8 0
I 4000fffc 0022202b 0 1 2 0 11111111 22222222 04 138 22222222 0000000a 0000202b 400180ac 0
I 5000fffc 00242824 1 0 0 0 11111111 22222222 05 138 00000005 00000005 00002824 5001a090 0
I 6000fffc 00222825 0 1 0 0 11111111 22222222 06 138 00000005 0000000a 00002825 6001a094 0
I 7000fffc 00222826 0 1 0 0 11111111 22222222 07 138 00000005 0000000a 00002826 7001a098 0
I 8000fffc 00222827 0 1 0 0 11111111 22222222 08 138 00000005 0000000a 00002827 8001a09c 0
I 9000fffc 00022900 0 1 0 0 11111111 22222222 09 128 00000000 0000000a 00002900 9001a400 0
I a000fffc 00022fc2 0 1 0 0 11111111 22222222 0a 128 00000000 0000000a 00002fc2 a001bf08 0
I b000fffc 00032a03 0 1 0 0 11111111 22222222 0b 128 00000000 ffffff00 00002a03 b001a80c 0
I c000fffc 2424fffc 0 1 0 0 11111111 22222222 00 110 00000005 00000005 fffffffc c000fff0 0
I d000fffc 28648000 0 1 0 0 11111111 22222222 03 110 ffffff00 00000005 ffff8000 cfff0000 0
I e000fffc 2c240010 0 1 0 0 11111111 22222222 04 110 00000005 00000005 00000010 e0010040 0
I 0000fffc 30248001 0 1 0 0 11111111 22222222 05 110 00000005 00000005 00008001 ffff0004 0
I 1100fffc 3444ffff 0 1 0 0 11111111 22222222 06 110 0000000a 00000005 0000ffff 1100fffc 0
I 1200fffc 382400ff 0 1 0 0 11111111 22222222 07 110 00000005 00000005 000000ff 120103fc 0
I 1300fffc 3c041234 0 1 0 0 11111111 22222222 01 110 00000000 00000005 00001234 130148d0 0
I 1400fffc 8c240008 0 1 0 0 11111111 22222222 00 150 00000005 00000005 00000008 14010020 0
I 1500fffc ac22fff8 0 1 0 0 11111111 22222222 00 090 00000005 0000000a fffffff8 1500ffe0 0
I 00400000 10240010 1 1 0 0 11111111 22222222 00 010 00000005 00000005 00000010 00400044 1
I 00400100 10220010 0 1 0 0 11111111 22222222 00 010 00000005 0000000a 00000010 00400144 0
I 00400200 1422fffe 0 1 0 0 11111111 22222222 00 010 00000005 0000000a fffffffe 004001fc 1
I 00400300 1424fffe 0 1 0 0 11111111 22222222 00 010 00000005 00000005 fffffffe 004002fc 0
I 00400400 04210010 0 1 0 0 11111111 22222222 00 010 00000005 00000005 00000010 00400444 1
I 00400500 04610010 0 1 0 0 11111111 22222222 00 010 ffffff00 00000005 00000010 00400544 0
I 00400600 04600010 0 1 0 0 11111111 22222222 00 010 ffffff00 00000000 00000010 00400644 1
I 00400700 04200010 0 1 0 0 11111111 22222222 00 010 00000005 00000000 00000010 00400744 0
I 00400800 1c200010 0 1 0 0 11111111 22222222 00 010 00000005 00000000 00000010 00400844 1
I 00400900 1c000010 0 1 0 0 11111111 22222222 00 010 00000000 00000000 00000010 00400944 0
I 00400a00 18000010 0 1 0 0 11111111 22222222 00 010 00000000 00000000 00000010 00400a44 1
I 00400b00 18200010 0 1 0 0 11111111 22222222 00 010 00000005 00000000 00000010 00400b44 0
I 10400c00 08010040 0 1 0 0 11111111 22222222 00 010 00000000 00000005 00000040 10040100 1
I 20400d00 0c010040 0 1 0 0 11111111 22222222 00 116 00000000 00000005 00000040 20040100 1
I 00400e00 03e00008 0 1 0 0 11111111 22222222 00 038 00400100 00000000 00000008 00400100 1
I 00400f00 03e0f809 0 1 1 0 00400200 22222222 00 13a 00400200 00000000 fffff809 00400200 1
I 00401000 fc000000 0 1 0 0 11111111 22222222 00 011 00000000 00000000 00000000 00401004 0
I 00401100 0000003f 0 1 0 0 11111111 22222222 00 039 00000000 00000000 0000003f 00401200 0
